// ==== vlog.f ====
logic/exu_pkg.sv
logic/exu_decoder.sv
logic/integer_unit.sv
logic/control_status_registers.sv
logic/exu_result_stage.sv
logic/execution_unit.sv
verif/exu_checker.sv
verif/execution_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execution stage testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module execution_unit_tb -o execution_unit_tb_sim
./obj_dir/execution_unit_tb_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== verif/execution_unit_tb.sv ====
/*
 * Execution stage testbench
 *
 * Builds a table of operations with expected results from a model of
 * the ALU and a shadow copy of the CSRs, applies one row per clock and
 * hands the expectations to the checker. A watchdog bounds the run.
 */

module execution_unit_tb;

    import exu_pkg::*;

    localparam int              CLK_PERIOD   = 8;
    localparam int              RESET_CYCLES = 10;
    localparam int              NUM_ROWS     = 29;
    localparam logic [XLEN-1:0] HART_ID_TB   = 32'd3;
    localparam logic [XLEN-1:0] SIGN_BIT     = 32'h8000_0000;

    // Opcode 3 reads without changing the register
    localparam logic [1:0]      CSR_KEEP     = 2'd3;

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              flush_i;
    logic              valid_i;
    logic              unit_sel_i;
    exu_uop_t          uop_i;
    logic [TAG_W-1:0]  tag_i;
    logic [XLEN-1:0]   operand_a_i;
    logic [XLEN-1:0]   operand_b_i;
    logic              valid_o;
    logic [XLEN-1:0]   result_o;
    logic [TAG_W-1:0]  tag_o;
    logic              exception_o;

    // Expectation of the row currently on the inputs
    logic              exp_push;
    logic              exp_valid;
    logic              exp_exception;
    logic [TAG_W-1:0]  exp_tag;
    logic [XLEN-1:0]   exp_result;
    int                rows_checked;
    int                error_count;

    //==================================================
    // Stimulus table and reference model state
    //==================================================

    logic              row_flush  [NUM_ROWS];
    logic              row_unit   [NUM_ROWS];
    exu_uop_t          row_uop    [NUM_ROWS];
    logic [XLEN-1:0]   row_a      [NUM_ROWS];
    logic [XLEN-1:0]   row_b      [NUM_ROWS];
    logic [XLEN-1:0]   row_result [NUM_ROWS];
    logic              row_exc    [NUM_ROWS];
    logic              row_valid  [NUM_ROWS];
    int                row_count;

    logic [XLEN-1:0]   shadow_mscratch;
    logic [XLEN-1:0]   shadow_mtvec;
    logic [XLEN-1:0]   shadow_minstret;
    logic [31:0]       lfsr_state;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit of the returned word
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < 32; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[31]};
        end
        return w;
    endfunction

    function automatic exu_uop_t alu_uop(input logic [3:0] op);
        exu_uop_t u;
        u = '0;
        u.itu.alu_op = op;
        return u;
    endfunction

    function automatic exu_uop_t csr_uop(input logic [1:0] op, input logic rd, input logic wr);
        exu_uop_t u;
        u = '0;
        u.csr.opcode = op;
        u.csr.read   = rd;
        u.csr.write  = wr;
        return u;
    endfunction

    function automatic logic [XLEN-1:0] csr_at(input logic [11:0] addr);
        return {20'h0, addr};
    endfunction

    // RV32 semantics written from the ISA with signed compares done by flipping the sign bit
    function automatic logic [XLEN-1:0] alu_model(input logic [3:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (~({XLEN{1'b1}} >> sh) & {XLEN{a[31]}});
            ALU_SLT:  return XLEN'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
            ALU_SLTU: return XLEN'(a < b);
            default:  return '0;
        endcase
    endfunction

    // Appends one row and advances the shadow state as the stage would
    task automatic add_row(input logic flush, input logic unit, input exu_uop_t uop,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [XLEN-1:0] old_value;
        logic [XLEN-1:0] new_value;
        logic [XLEN-1:0] result;
        logic            mapped;
        logic            illegal;
        old_value = '0;
        new_value = '0;
        mapped    = 1'b1;
        if (unit == UNIT_ITU) begin
            illegal = (uop.itu.alu_op > 4'd9);
            result  = illegal ? '0 : alu_model(uop.itu.alu_op, a, b);
            if (!illegal && !flush) begin
                shadow_minstret = shadow_minstret + 32'd1;
            end
        end else begin
            case (b[11:0])
                CSR_MSCRATCH: old_value = shadow_mscratch;
                CSR_MTVEC:    old_value = shadow_mtvec;
                CSR_MINSTRET: old_value = shadow_minstret;
                CSR_MHARTID:  old_value = HART_ID_TB;
                default:      mapped = 1'b0;
            endcase
            illegal = !mapped || (uop.csr.write && (b[11:10] == 2'b11));
            result  = (uop.csr.read && !illegal) ? old_value : '0;
            case (uop.csr.opcode)
                CSR_SWAP:  new_value = a;
                CSR_SET:   new_value = old_value | a;
                CSR_CLEAR: new_value = old_value & ~a;
                default:   new_value = old_value;
            endcase
            if (uop.csr.write && !illegal && !flush) begin
                case (b[11:0])
                    CSR_MSCRATCH: shadow_mscratch = new_value;
                    CSR_MTVEC:    shadow_mtvec = {new_value[XLEN-1:2], 2'b00};
                    CSR_MINSTRET: shadow_minstret = new_value;
                    default:      shadow_mscratch = shadow_mscratch;
                endcase
            end
        end
        row_flush[row_count]  = flush;
        row_unit[row_count]   = unit;
        row_uop[row_count]    = uop;
        row_a[row_count]      = a;
        row_b[row_count]      = b;
        row_result[row_count] = result;
        row_exc[row_count]    = illegal && !flush;
        row_valid[row_count]  = !flush;
        row_count = row_count + 1;
    endtask

    task automatic build_table();
        logic [XLEN-1:0] a_edge [4];
        logic [XLEN-1:0] b;
        // Every register reads zero straight out of reset
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MSCRATCH));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MTVEC));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MINSTRET));
        // All ten ALU codes over edge first operands with shifts by 31 and junk upper bits
        a_edge[0] = SIGN_BIT;
        a_edge[1] = 32'hffff_ffff;
        a_edge[2] = 32'h0;
        a_edge[3] = random_word();
        for (int op = 0; op < 10; op++) begin
            b = random_word();
            if (op >= 5 && op <= 7) begin
                b = b | 32'd31;
            end
            add_row(1'b0, UNIT_ITU, alu_uop(4'(op)), a_edge[(op + 2) % 4], b);
        end
        add_row(1'b0, UNIT_ITU, alu_uop(4'd12), random_word(), random_word());
        // Swap, set and clear each return the value left by the one before
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_SWAP, 1'b1, 1'b1), random_word(),
                csr_at(CSR_MSCRATCH));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_SET, 1'b1, 1'b1), random_word(),
                csr_at(CSR_MSCRATCH));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_CLEAR, 1'b1, 1'b1), random_word(),
                csr_at(CSR_MSCRATCH));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_SWAP, 1'b1, 1'b1), 32'h1234_5677, csr_at(CSR_MTVEC));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MTVEC));
        // Hart id, a refused write to it, and an unmapped address
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MHARTID));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_SWAP, 1'b1, 1'b1), random_word(),
                csr_at(CSR_MHARTID));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MHARTID));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(12'h7C0));
        // A flushed write must not reach mscratch
        add_row(1'b1, UNIT_CSR, csr_uop(CSR_SWAP, 1'b1, 1'b1), random_word(),
                csr_at(CSR_MSCRATCH));
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MSCRATCH));
        // Retire count restarts from a written value and flushed ops do not count
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_SWAP, 1'b1, 1'b1), 32'd100, csr_at(CSR_MINSTRET));
        add_row(1'b1, UNIT_ITU, alu_uop(ALU_ADD), random_word(), random_word());
        add_row(1'b0, UNIT_ITU, alu_uop(ALU_SLL), random_word(), random_word());
        add_row(1'b0, UNIT_CSR, csr_uop(CSR_KEEP, 1'b1, 1'b0), '0, csr_at(CSR_MINSTRET));
    endtask

    //==================================================
    // DUT and checker
    //==================================================

    execution_unit #(
        .HART_ID ( HART_ID_TB )
    ) i_execution_unit (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .flush_i     ( flush_i     ),
        .valid_i     ( valid_i     ),
        .unit_sel_i  ( unit_sel_i  ),
        .uop_i       ( uop_i       ),
        .tag_i       ( tag_i       ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .valid_o     ( valid_o     ),
        .result_o    ( result_o    ),
        .tag_o       ( tag_o       ),
        .exception_o ( exception_o )
    );

    exu_checker i_exu_checker (
        .clk_i           ( clk_i         ),
        .rst_n_i         ( rst_n_i       ),
        .dut_valid_i     ( valid_o       ),
        .dut_result_i    ( result_o      ),
        .dut_tag_i       ( tag_o         ),
        .dut_exception_i ( exception_o   ),
        .exp_push_i      ( exp_push      ),
        .exp_valid_i     ( exp_valid     ),
        .exp_result_i    ( exp_result    ),
        .exp_tag_i       ( exp_tag       ),
        .exp_exception_i ( exp_exception ),
        .rows_checked_o  ( rows_checked  ),
        .errors_o        ( error_count   )
    );

    initial begin : clock_gen
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Bound on the run sized from the table and the reset length
    initial begin : watchdog
        #((NUM_ROWS + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Run timed out at %0t with %0d of %0d rows checked",
                 $time, rows_checked, NUM_ROWS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        valid_i         = 1'b0;
        unit_sel_i      = UNIT_ITU;
        uop_i           = '0;
        tag_i           = '0;
        operand_a_i     = '0;
        operand_b_i     = '0;
        exp_push        = 1'b0;
        exp_valid       = 1'b0;
        exp_exception   = 1'b0;
        exp_tag         = '0;
        exp_result      = '0;
        row_count       = 0;
        shadow_mscratch = '0;
        shadow_mtvec    = '0;
        shadow_minstret = '0;
        lfsr_state      = 32'h790ae984;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // One row per cycle with the row number as tag
        for (int i = 0; i < row_count; i++) begin
            @(posedge clk_i);
            flush_i       <= row_flush[i];
            valid_i       <= 1'b1;
            unit_sel_i    <= row_unit[i];
            uop_i         <= row_uop[i];
            tag_i         <= TAG_W'(i);
            operand_a_i   <= row_a[i];
            operand_b_i   <= row_b[i];
            exp_push      <= 1'b1;
            exp_valid     <= row_valid[i];
            exp_exception <= row_exc[i];
            exp_tag       <= TAG_W'(i);
            exp_result    <= row_result[i];
        end
        @(posedge clk_i);
        valid_i  <= 1'b0;
        flush_i  <= 1'b0;
        exp_push <= 1'b0;

        wait (rows_checked == row_count);
        repeat (2) @(posedge clk_i);
        $display("Checked %0d of %0d rows, %0d errors", rows_checked, row_count, error_count);
        if (error_count == 0 && rows_checked == NUM_ROWS) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : execution_unit_tb

// ==== verif/exu_checker.sv ====
/*
 * Execution stage result checker
 *
 * Queues the expectation of each issued row and compares it with the
 * registered outputs one cycle later, sampling on the falling edge.
 */

module exu_checker (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      dut_valid_i,
    input  logic [exu_pkg::XLEN-1:0]  dut_result_i,
    input  logic [exu_pkg::TAG_W-1:0] dut_tag_i,
    input  logic                      dut_exception_i,
    input  logic                      exp_push_i,
    input  logic                      exp_valid_i,
    input  logic [exu_pkg::XLEN-1:0]  exp_result_i,
    input  logic [exu_pkg::TAG_W-1:0] exp_tag_i,
    input  logic                      exp_exception_i,
    output int                        rows_checked_o,
    output int                        errors_o
);

    import exu_pkg::*;

    // Entries packed as valid, exception, tag and result
    logic [XLEN+TAG_W+1:0] pending [$];

    initial begin
        rows_checked_o = 0;
        errors_o       = 0;
    end

    function automatic int check_field(input string what, input logic [XLEN-1:0] got,
                                       input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
            return 1;
        end
        return 0;
    endfunction

    always @(negedge clk_i) begin : compare
        logic [XLEN+TAG_W+1:0] entry;
        int                    row_errors;
        row_errors = 0;
        if (!rst_n_i) begin
            if (dut_valid_i || dut_exception_i || (dut_result_i != '0) || (dut_tag_i != '0)) begin
                $display("Outputs are not at their reset values while reset is applied");
                errors_o = errors_o + 1;
            end
        end else if (pending.size() > 0) begin
            entry = pending.pop_front();
            row_errors += check_field("valid_o", XLEN'(dut_valid_i), XLEN'(entry[XLEN+TAG_W+1]));
            // A flushed row only has to drop valid_o
            if (entry[XLEN+TAG_W+1]) begin
                row_errors += check_field("tag_o", XLEN'(dut_tag_i), XLEN'(entry[XLEN+:TAG_W]));
                row_errors += check_field("exception_o", XLEN'(dut_exception_i),
                                          XLEN'(entry[XLEN+TAG_W]));
                row_errors += check_field("result_o", dut_result_i, entry[XLEN-1:0]);
            end
            $display("Row %0d tag %0d %s", rows_checked_o, entry[XLEN+:TAG_W],
                     (row_errors == 0) ? "ok" : "mismatch");
            errors_o       = errors_o + row_errors;
            rows_checked_o = rows_checked_o + 1;
        end else if (dut_valid_i || dut_exception_i) begin
            $display("valid_o or exception_o is high with no operation outstanding");
            errors_o = errors_o + 1;
        end
        if (exp_push_i) begin
            pending.push_back({exp_valid_i, exp_exception_i, exp_tag_i, exp_result_i});
        end
    end

endmodule : exu_checker

// ==== logic/execution_unit.sv ====
/*
 * In-order RV32 execution stage
 *
 * Decodes each operation, runs it on the integer ALU or the CSR unit
 * and returns one registered result with its tag and exception flag
 * one cycle later.
 */

module execution_unit #(
    parameter logic [exu_pkg::XLEN-1:0] HART_ID = '0
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Incoming operation
    input  logic                      valid_i,
    input  logic                      unit_sel_i,
    input  exu_pkg::exu_uop_t         uop_i,
    input  logic [exu_pkg::TAG_W-1:0] tag_i,
    input  logic [exu_pkg::XLEN-1:0]  operand_a_i,
    input  logic [exu_pkg::XLEN-1:0]  operand_b_i,

    // Registered result
    output logic                      valid_o,
    output logic [exu_pkg::XLEN-1:0]  result_o,
    output logic [exu_pkg::TAG_W-1:0] tag_o,
    output logic                      exception_o
);

    import exu_pkg::*;

    logic            itu_valid;
    logic [3:0]      alu_op;
    logic            alu_illegal;
    logic [XLEN-1:0] alu_result;

    logic            csr_valid;
    logic [1:0]      csr_opcode;
    logic            csr_read;
    logic            csr_write;
    logic [XLEN-1:0] csr_rdata;
    logic            csr_illegal;

    logic            retire;

    //==================================================
    // Decode and units
    //==================================================

    exu_decoder i_exu_decoder (
        .valid_i       ( valid_i     ),
        .unit_sel_i    ( unit_sel_i  ),
        .uop_i         ( uop_i       ),
        .itu_valid_o   ( itu_valid   ),
        .alu_op_o      ( alu_op      ),
        .alu_illegal_o ( alu_illegal ),
        .csr_valid_o   ( csr_valid   ),
        .csr_opcode_o  ( csr_opcode  ),
        .csr_read_o    ( csr_read    ),
        .csr_write_o   ( csr_write   )
    );

    integer_unit i_integer_unit (
        .alu_op_i    ( alu_op      ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .result_o    ( alu_result  )
    );

    // Only legal integer operations that survive the flush retire
    assign retire = itu_valid & ~alu_illegal & ~flush_i;

    // Source operand is the write data, second operand holds the address
    control_status_registers #(
        .HART_ID ( HART_ID )
    ) i_control_status_registers (
        .clk_i         ( clk_i              ),
        .rst_n_i       ( rst_n_i            ),
        .flush_i       ( flush_i            ),
        .csr_valid_i   ( csr_valid          ),
        .csr_opcode_i  ( csr_opcode         ),
        .csr_read_i    ( csr_read           ),
        .csr_write_i   ( csr_write          ),
        .csr_address_i ( operand_b_i[11:0]  ),
        .csr_wsource_i ( operand_a_i        ),
        .retire_i      ( retire             ),
        .csr_rdata_o   ( csr_rdata          ),
        .csr_illegal_o ( csr_illegal        )
    );

    //==================================================
    // Result register
    //==================================================

    exu_result_stage i_exu_result_stage (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .flush_i       ( flush_i     ),
        .itu_valid_i   ( itu_valid   ),
        .alu_illegal_i ( alu_illegal ),
        .alu_result_i  ( alu_result  ),
        .csr_valid_i   ( csr_valid   ),
        .csr_illegal_i ( csr_illegal ),
        .csr_rdata_i   ( csr_rdata   ),
        .tag_i         ( tag_i       ),
        .valid_o       ( valid_o     ),
        .result_o      ( result_o    ),
        .tag_o         ( tag_o       ),
        .exception_o   ( exception_o )
    );

endmodule : execution_unit

// ==== logic/exu_result_stage.sv ====
/*
 * Execution stage result register
 *
 * Picks the value of the unit that owned the operation, folds in its
 * illegal flag and registers result, tag, exception and valid so that
 * every operation completes exactly one cycle after it arrives.
 */

module exu_result_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Integer ALU side
    input  logic                      itu_valid_i,
    input  logic                      alu_illegal_i,
    input  logic [exu_pkg::XLEN-1:0]  alu_result_i,

    // CSR unit side
    input  logic                      csr_valid_i,
    input  logic                      csr_illegal_i,
    input  logic [exu_pkg::XLEN-1:0]  csr_rdata_i,

    input  logic [exu_pkg::TAG_W-1:0] tag_i,

    output logic                      valid_o,
    output logic [exu_pkg::XLEN-1:0]  result_o,
    output logic [exu_pkg::TAG_W-1:0] tag_o,
    output logic                      exception_o
);

    import exu_pkg::*;

    logic            valid_d;
    logic            exception_d;
    logic [XLEN-1:0] result_d;

    // Flush kills the operation before it reaches the register
    assign valid_d = (itu_valid_i | csr_valid_i) & ~flush_i;

    // Exception flag comes from whichever unit produced the value
    assign exception_d = valid_d & ((itu_valid_i & alu_illegal_i) |
                                    (csr_valid_i & csr_illegal_i));

    // An excepting operation never exposes a value
    always_comb begin
        result_d = itu_valid_i ? alu_result_i : csr_rdata_i;
        if (exception_d) begin
            result_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o     <= 1'b0;
            exception_o <= 1'b0;
            result_o    <= '0;
            tag_o       <= '0;
        end else begin
            valid_o     <= valid_d;
            exception_o <= exception_d;
            result_o    <= result_d;
            tag_o       <= tag_i;
        end
    end

    // Exceptions only ride on a live result, and carry zero
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exception_o |-> (valid_o && (result_o == '0)))
        else $error("Exception raised without a valid zero result");

endmodule : exu_result_stage

// ==== logic/control_status_registers.sv ====
/*
 * Machine control and status registers
 *
 * Holds mscratch, mtvec and minstret and returns the hart id. Reads
 * are combinational, writes apply swap, set or clear to the old value
 * at the capturing edge. Unmapped addresses and writes to read-only
 * registers are reported as illegal.
 */

module control_status_registers #(
    parameter logic [exu_pkg::XLEN-1:0] HART_ID = '0
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,

    // Access request from the decoder
    input  logic                     csr_valid_i,
    input  logic [1:0]               csr_opcode_i,
    input  logic                     csr_read_i,
    input  logic                     csr_write_i,
    input  logic [11:0]              csr_address_i,
    input  logic [exu_pkg::XLEN-1:0] csr_wsource_i,

    // Completed integer operation
    input  logic                     retire_i,

    output logic [exu_pkg::XLEN-1:0] csr_rdata_o,
    output logic                     csr_illegal_o
);

    import exu_pkg::*;

    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] minstret_q;

    logic [XLEN-1:0] csr_value;
    logic [XLEN-1:0] csr_wdata;
    logic            csr_mapped;
    logic            csr_read_only;
    logic            csr_wr_en;

    //==================================================
    // Read path and access check
    //==================================================

    // Old value of the addressed register, also the base of the write
    always_comb begin
        csr_mapped = 1'b1;
        csr_value  = '0;

        case (csr_address_i)
            CSR_MSCRATCH: csr_value = mscratch_q;
            CSR_MTVEC:    csr_value = mtvec_q;
            CSR_MINSTRET: csr_value = minstret_q;
            CSR_MHARTID:  csr_value = HART_ID;
            default:      csr_mapped = 1'b0;
        endcase
    end

    // Top two address bits at 2'b11 mark the read-only space
    assign csr_read_only = (csr_address_i[11:10] == 2'b11);

    assign csr_illegal_o = csr_valid_i & (~csr_mapped | (csr_write_i & csr_read_only));

    // Nothing leaves the unit on an illegal access or without a read
    assign csr_rdata_o = (csr_read_i && !csr_illegal_o) ? csr_value : '0;

    //==================================================
    // Write path
    //==================================================

    // New value built from the old one and the source operand
    always_comb begin
        case (csr_opcode_i)
            CSR_SWAP:  csr_wdata = csr_wsource_i;
            CSR_SET:   csr_wdata = csr_value | csr_wsource_i;
            CSR_CLEAR: csr_wdata = csr_value & ~csr_wsource_i;
            default:   csr_wdata = csr_value;
        endcase
    end

    // A flushed operation must leave the architectural state alone
    assign csr_wr_en = csr_valid_i & csr_write_i & ~flush_i & ~csr_illegal_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            minstret_q <= '0;
        end else begin
            if (csr_wr_en && (csr_address_i == CSR_MSCRATCH)) begin
                mscratch_q <= csr_wdata;
            end

            // Trap vector is word aligned, mode bits stay zero
            if (csr_wr_en && (csr_address_i == CSR_MTVEC)) begin
                mtvec_q <= {csr_wdata[XLEN-1:2], 2'b00};
            end

            // A cycle carries one operation so write and retire never meet
            if (csr_wr_en && (csr_address_i == CSR_MINSTRET)) begin
                minstret_q <= csr_wdata;
            end else if (retire_i) begin
                minstret_q <= minstret_q + 1'b1;
            end
        end
    end

    // A write aimed at mhartid is refused and disturbs no register
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (csr_valid_i && csr_write_i && (csr_address_i == CSR_MHARTID))
        |-> csr_illegal_o ##1 ($stable(mscratch_q) && $stable(mtvec_q)
                               && $stable(minstret_q)))
        else $error("Write to mhartid changed CSR state");

endmodule : control_status_registers

// ==== logic/integer_unit.sv ====
/*
 * RV32 integer ALU
 *
 * Combinational arithmetic, logic, shift and compare operations on
 * two XLEN operands. Shift amounts come from the low five bits of
 * the second operand, undefined codes give zero.
 */

module integer_unit (
    input  logic [3:0]               alu_op_i,
    input  logic [exu_pkg::XLEN-1:0] operand_a_i,
    input  logic [exu_pkg::XLEN-1:0] operand_b_i,
    output logic [exu_pkg::XLEN-1:0] result_o
);

    import exu_pkg::*;

    // RV32 shifts only look at five bits of the amount
    logic [4:0] shamt;

    // Signed views used by SRA and SLT
    logic signed [XLEN-1:0] operand_a_s;
    logic signed [XLEN-1:0] operand_b_s;

    assign shamt       = operand_b_i[4:0];
    assign operand_a_s = operand_a_i;
    assign operand_b_s = operand_b_i;

    //==================================================
    // Operation select
    //==================================================

    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                result_o = operand_a_i + operand_b_i;
            end

            ALU_SUB: begin
                result_o = operand_a_i - operand_b_i;
            end

            ALU_AND: begin
                result_o = operand_a_i & operand_b_i;
            end

            ALU_OR: begin
                result_o = operand_a_i | operand_b_i;
            end

            ALU_XOR: begin
                result_o = operand_a_i ^ operand_b_i;
            end

            ALU_SLL: begin
                result_o = operand_a_i << shamt;
            end

            ALU_SRL: begin
                result_o = operand_a_i >> shamt;
            end

            // Sign bit is replicated into the vacated positions
            ALU_SRA: begin
                result_o = operand_a_s >>> shamt;
            end

            // Compares return 0 or 1 zero extended to the word
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, (operand_a_s < operand_b_s)};
            end

            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, (operand_a_i < operand_b_i)};
            end

            // Undefined code, the decoder raises the exception
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule : integer_unit

// ==== logic/exu_decoder.sv ====
/*
 * Execution stage operation decoder
 *
 * Steers an incoming operation to the integer ALU or to the CSR unit,
 * reading the operation word through the matching view, and flags
 * ALU codes outside the defined range.
 */

module exu_decoder (
    input  logic              valid_i,
    input  logic              unit_sel_i,
    input  exu_pkg::exu_uop_t uop_i,

    // Integer ALU controls
    output logic              itu_valid_o,
    output logic [3:0]        alu_op_o,
    output logic              alu_illegal_o,

    // CSR unit controls
    output logic              csr_valid_o,
    output logic [1:0]        csr_opcode_o,
    output logic              csr_read_o,
    output logic              csr_write_o
);

    import exu_pkg::*;

    //==================================================
    // Unit steering
    //==================================================

    // The strobe reaches only the unit picked by the select bit
    assign itu_valid_o = valid_i & (unit_sel_i == UNIT_ITU);
    assign csr_valid_o = valid_i & (unit_sel_i == UNIT_CSR);

    //==================================================
    // Operation word views
    //==================================================

    // In the ALU view codes above SLTU have no operation behind them
    assign alu_op_o      = uop_i.itu.alu_op;
    assign alu_illegal_o = itu_valid_o & (uop_i.itu.alu_op > ALU_SLTU);

    // CSR view of the same bits
    assign csr_opcode_o = uop_i.csr.opcode;
    assign csr_read_o   = uop_i.csr.read;
    assign csr_write_o  = uop_i.csr.write;

endmodule : exu_decoder

// ==== logic/exu_pkg.sv ====
/*
 * Execution stage shared definitions
 *
 * Word and tag widths, the unit select values, the ALU and CSR
 * operation codes, the machine CSR addresses and the operation word
 * that the integer ALU and the CSR unit decode in two different ways.
 */

package exu_pkg;

    // Data word and instruction tag widths
    localparam int XLEN  = 32;
    localparam int TAG_W = 6;

    // Unit select, one bit wide since only two units exist
    localparam logic UNIT_ITU = 1'b0;
    localparam logic UNIT_CSR = 1'b1;

    //==================================================
    // Integer ALU operation codes
    //==================================================

    // Codes 10 to 15 of the 4-bit field are undefined
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_AND  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_SLL  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_SLT  = 4'd8;
    localparam logic [3:0] ALU_SLTU = 4'd9;

    //==================================================
    // CSR operation codes and addresses
    //==================================================

    // Code 3 leaves the register with its current value
    localparam logic [1:0] CSR_SWAP  = 2'd0;
    localparam logic [1:0] CSR_SET   = 2'd1;
    localparam logic [1:0] CSR_CLEAR = 2'd2;

    // Addresses with 2'b11 in the top two bits are read-only
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MINSTRET = 12'hB02;
    localparam logic [11:0] CSR_MHARTID  = 12'hF14;

    // View of the operation word as seen by the integer ALU
    typedef struct packed {
        logic [3:0] spare;
        logic [3:0] alu_op;
    } itu_uop_t;

    // View of the operation word as seen by the CSR unit
    typedef struct packed {
        logic [3:0] spare;
        logic       read;
        logic       write;
        logic [1:0] opcode;
    } csr_uop_t;

    // One 8-bit word, meaning chosen by the unit select
    typedef union packed {
        itu_uop_t itu;
        csr_uop_t csr;
    } exu_uop_t;

endpackage : exu_pkg
